// ==== source/pe_cfg.svh ====
`ifndef PE_CFG_SVH
`define PE_CFG_SVH

// Activation and weight width
`define PE_OPND_W  8

// One word of the multiplier's sum/carry pair
`define PE_PROD_W  16

// One word of an accumulator pair
`define PE_ACC_W   32

// Result and preload width
`define PE_OUT_W   19

// Rounding shift amount
`define PE_SHIFT_W 5

`endif

// ==== source/pe_pkg.sv ====
`include "pe_cfg.svh"

package pe_pkg;

  typedef logic signed [`PE_OPND_W-1:0]  opnd_t;    // Signed activation or weight
  typedef logic signed [`PE_PROD_W-1:0]  prod_t;    // Product sum or carry word
  typedef logic signed [`PE_ACC_W-1:0]   acc_t;     // Accumulator sum or carry word
  typedef logic signed [`PE_OUT_W-1:0]   pe_out_t;  // Result or preload value
  typedef logic        [`PE_SHIFT_W-1:0] shift_t;   // Shift amount, unsigned

  // Request into the element
  typedef struct packed {
    opnd_t   a;          // Activation
    opnd_t   b;          // Weight
    pe_out_t d;          // Preload for the drained buffer
    logic    propagate;  // High drains buffer one
    shift_t  shift;      // Only honoured on a propagate flip
  } pe_req_t;

  // Multiply stage to accumulate stage
  typedef struct packed {
    prod_t   prod_s;     // Product sum word
    prod_t   prod_c;     // Product carry word
    pe_out_t d;          // Preload, passed along
    logic    propagate;
    shift_t  shift;      // Raw shift, flip not yet known
  } prod_beat_t;

  // Accumulate stage to round stage
  typedef struct packed {
    acc_t    drain_s;    // Old sum word of drained buffer
    acc_t    drain_c;    // Old carry word of drained buffer
    shift_t  shift;      // Zero unless propagate flipped
  } drain_beat_t;

endpackage

// ==== source/booth_mult_stage.sv ====
`timescale 1ns/10ps
`include "pe_cfg.svh"

module booth_mult_stage
  import pe_pkg::*;
(
  input  logic       CLK,
  input  logic       rst_n,
  input  logic       in_valid,      // Request offered
  output logic       in_ready,      // Slot empty or emptying
  input  pe_req_t    in_req,
  output logic       out_valid,     // Product pair held
  input  logic       out_ready,
  output prod_beat_t out_beat
);

  localparam int MW  = `PE_OPND_W + 1;  // Room for 2a
  localparam int NPP = `PE_OPND_W / 2;  // Radix-4 digit count

  logic [`PE_OPND_W:0] b_ext;           // Weight with implied zero below LSB
  logic [2:0]          trip [NPP];      // Booth triplet per digit
  logic [MW-1:0]       mult [NPP];      // Selected multiple 0, a or 2a
  logic [MW-1:0]       row  [NPP];      // Inverted when digit is negative
  prod_t               pp   [NPP];      // Sign-extended, shifted rows
  prod_t               neg_vec;         // Plus-one bits of inverted rows
  prod_t               s1;
  prod_t               c1;
  prod_t               s2;
  prod_t               c2;
  prod_t               s3;              // Final sum word
  prod_t               c3;              // Final carry word, already aligned
  logic                in_fire;

  always_comb begin
    b_ext   = {in_req.b, 1'b0};
    neg_vec = '0;
    for (int i = 0; i < NPP; i++) begin
      trip[i] = b_ext[2*i +: 3];
      case (trip[i])
        3'b001, 3'b010, 3'b101, 3'b110: mult[i] = {in_req.a[`PE_OPND_W-1], in_req.a};  // a
        3'b011, 3'b100:                 mult[i] = {in_req.a, 1'b0};                    // 2a
        default:                        mult[i] = '0;
      endcase
      row[i]        = trip[i][2] ? ~mult[i] : mult[i];  // Ones complement for -a, -2a
      pp[i]         = {{(`PE_PROD_W - MW){row[i][MW-1]}}, row[i]} << (2 * i);
      neg_vec[2*i]  = trip[i][2];                       // Completes the negation
    end

    // Narrow rows first so both output words stay sign-correct in 16 bits
    s1 = pp[0] ^ pp[1] ^ neg_vec;
    c1 = ((pp[0] & pp[1]) | (pp[0] & neg_vec) | (pp[1] & neg_vec)) << 1;
    s2 = s1 ^ c1 ^ pp[2];
    c2 = ((s1 & c1) | (s1 & pp[2]) | (c1 & pp[2])) << 1;
    s3 = s2 ^ c2 ^ pp[3];
    c3 = ((s2 & c2) | (s2 & pp[3]) | (c2 & pp[3])) << 1;
  end

  assign in_ready = !out_valid || out_ready;
  assign in_fire  = in_valid && in_ready;

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else if (in_ready) begin
      out_valid <= in_valid;           // Refill or empty the slot
    end
  end

  always_ff @(posedge CLK) begin
    if (in_fire) begin
      out_beat.prod_s    <= s3;
      out_beat.prod_c    <= c3;
      out_beat.d         <= in_req.d;
      out_beat.propagate <= in_req.propagate;
      out_beat.shift     <= in_req.shift;
    end
  end

  // Stalled beat must not change under the accumulate stage
  a_hold_beat: assert property (@(posedge CLK) disable iff (!rst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_beat));

endmodule

// ==== source/csa_accum_stage.sv ====
`timescale 1ns/10ps
`include "pe_cfg.svh"

module csa_accum_stage
  import pe_pkg::*;
(
  input  logic        CLK,
  input  logic        rst_n,
  input  logic        in_valid,
  output logic        in_ready,
  input  prod_beat_t  in_beat,
  output logic        out_valid,     // Drained pair held
  input  logic        out_ready,
  output drain_beat_t out_beat
);

  localparam int PEXT = `PE_ACC_W - `PE_PROD_W;  // Product sign extension
  localparam int DEXT = `PE_ACC_W - `PE_OUT_W;   // Preload sign extension

  acc_t  buf1_s;          // Buffer one, drained when propagate high
  acc_t  buf1_c;
  acc_t  buf2_s;          // Buffer two, drained when propagate low
  acc_t  buf2_c;
  logic  last_prop;       // Propagate of last accepted request
  logic  in_fire;
  logic  flip;            // Propagate changed on this request
  acc_t  d_ext;
  acc_t  p_s_ext;
  acc_t  p_c_ext;
  acc_t  src_s;           // Accumulating buffer, old value
  acc_t  src_c;
  acc_t  r1_s;            // First compressor row adds product sum
  acc_t  r1_c;
  acc_t  r2_s;            // Second row adds product carry
  acc_t  r2_c;

  always_comb begin
    flip    = in_beat.propagate != last_prop;
    d_ext   = {{DEXT{in_beat.d[`PE_OUT_W-1]}}, in_beat.d};
    p_s_ext = {{PEXT{in_beat.prod_s[`PE_PROD_W-1]}}, in_beat.prod_s};
    p_c_ext = {{PEXT{in_beat.prod_c[`PE_PROD_W-1]}}, in_beat.prod_c};
    src_s   = in_beat.propagate ? buf2_s : buf1_s;
    src_c   = in_beat.propagate ? buf2_c : buf1_c;
    r1_s    = src_s ^ src_c ^ p_s_ext;
    r1_c    = ((src_s & src_c) | (src_s & p_s_ext) | (src_c & p_s_ext)) << 1;
    r2_s    = r1_s ^ r1_c ^ p_c_ext;
    r2_c    = ((r1_s & r1_c) | (r1_s & p_c_ext) | (r1_c & p_c_ext)) << 1;
  end

  assign in_ready = !out_valid || out_ready;
  assign in_fire  = in_valid && in_ready;

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      buf1_s    <= '0;
      buf1_c    <= '0;
      buf2_s    <= '0;
      buf2_c    <= '0;
      last_prop <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      if (in_ready) begin
        out_valid <= in_valid;
      end
      if (in_fire) begin
        if (in_beat.propagate) begin
          buf1_s <= d_ext;              // Preload after drain
          buf1_c <= '0;
          buf2_s <= r2_s;
          buf2_c <= r2_c;
        end else begin
          buf2_s <= d_ext;
          buf2_c <= '0;
          buf1_s <= r2_s;
          buf1_c <= r2_c;
        end
        last_prop <= in_beat.propagate;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (in_fire) begin
      out_beat.drain_s <= in_beat.propagate ? buf1_s : buf2_s;  // Value before update
      out_beat.drain_c <= in_beat.propagate ? buf1_c : buf2_c;
      out_beat.shift   <= flip ? in_beat.shift : '0;
    end
  end

  // Compressor rows must match a plain add into the accumulating buffer
  a_accum_sum: assert property (@(posedge CLK) disable iff (!rst_n)
    in_fire |=> ((last_prop ? buf2_s + buf2_c : buf1_s + buf1_c)
                 == $past(src_s + src_c + p_s_ext + p_c_ext)));

endmodule

// ==== source/round_sat_stage.sv ====
`timescale 1ns/10ps
`include "pe_cfg.svh"

module round_sat_stage
  import pe_pkg::*;
(
  input  logic        CLK,
  input  logic        rst_n,
  input  logic        in_valid,
  output logic        in_ready,
  input  drain_beat_t in_beat,
  output logic        res_valid,    // Result held
  input  logic        res_ready,
  output pe_out_t     res
);

  localparam acc_t SAT_MAX = acc_t'((1 << (`PE_OUT_W - 1)) - 1);  // 2^18-1
  localparam acc_t SAT_MIN = acc_t'(-(1 << (`PE_OUT_W - 1)));     // -2^18

  acc_t    total;       // Resolved binary value
  acc_t    shifted;     // Floor of total / 2^shift
  acc_t    low_mask;    // Bits below the half bit
  acc_t    rounded;
  logic    half_bit;
  logic    sticky;      // Anything below half
  logic    round_up;
  pe_out_t sat_val;
  logic    in_fire;

  always_comb begin
    total   = in_beat.drain_s + in_beat.drain_c;
    shifted = total >>> in_beat.shift;
    if (in_beat.shift != '0) begin
      low_mask = (acc_t'(1) << (in_beat.shift - 1'b1)) - acc_t'(1);
      half_bit = total[in_beat.shift - 1'b1];
      sticky   = |(total & low_mask);
      round_up = half_bit && (sticky || shifted[0]);  // Ties go to even
    end else begin
      low_mask = '0;
      half_bit = 1'b0;
      sticky   = 1'b0;
      round_up = 1'b0;
    end
    rounded = shifted + acc_t'(round_up);
    if (rounded > SAT_MAX) begin
      sat_val = SAT_MAX[`PE_OUT_W-1:0];
    end else if (rounded < SAT_MIN) begin
      sat_val = SAT_MIN[`PE_OUT_W-1:0];
    end else begin
      sat_val = rounded[`PE_OUT_W-1:0];
    end
  end

  assign in_ready = !res_valid || res_ready;
  assign in_fire  = in_valid && in_ready;

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      res_valid <= 1'b0;
    end else if (in_ready) begin
      res_valid <= in_valid;
    end
  end

  always_ff @(posedge CLK) begin
    if (in_fire) begin
      res <= sat_val;
    end
  end

  // Result stays put until the consumer takes it
  a_hold_res: assert property (@(posedge CLK) disable iff (!rst_n)
    res_valid && !res_ready |=> res_valid && $stable(res));

endmodule

// ==== source/pe_top.sv ====
`timescale 1ns/10ps
`include "pe_cfg.svh"

module pe_top
  import pe_pkg::*;
(
  input  logic    CLK,
  input  logic    rst_n,
  input  logic    req_valid,     // Request offered
  output logic    req_ready,     // Multiply stage can take it
  input  pe_req_t req,
  output logic    res_valid,     // Result three cycles after request
  input  logic    res_ready,
  output pe_out_t res
);

  logic        prod_valid;     // Multiply to accumulate link
  logic        prod_ready;
  prod_beat_t  prod_beat;
  logic        drain_valid;    // Accumulate to round link
  logic        drain_ready;
  drain_beat_t drain_beat;

  // Stage one, Booth product as sum/carry pair
  booth_mult_stage mult_i (
    .CLK       (CLK),
    .rst_n     (rst_n),
    .in_valid  (req_valid),
    .in_ready  (req_ready),
    .in_req    (req),
    .out_valid (prod_valid),
    .out_ready (prod_ready),
    .out_beat  (prod_beat)
  );

  // Stage two, double buffer and flip detect
  csa_accum_stage accum_i (
    .CLK       (CLK),
    .rst_n     (rst_n),
    .in_valid  (prod_valid),
    .in_ready  (prod_ready),
    .in_beat   (prod_beat),
    .out_valid (drain_valid),
    .out_ready (drain_ready),
    .out_beat  (drain_beat)
  );

  // Stage three, resolve, round, clamp
  round_sat_stage round_i (
    .CLK       (CLK),
    .rst_n     (rst_n),
    .in_valid  (drain_valid),
    .in_ready  (drain_ready),
    .in_beat   (drain_beat),
    .res_valid (res_valid),
    .res_ready (res_ready),
    .res       (res)
  );

endmodule

// ==== tb/pe_tb.sv ====
`timescale 1ns/10ps
`include "pe_cfg.svh"

module pe_tb
  import pe_pkg::*;
();

  localparam int STREAM_LEN  = 200;                    // Back-pressure stream length
  localparam int TOTAL_REQS  = STREAM_LEN + 81;        // All tests together
  localparam int CYCLE_LIMIT = 4 * TOTAL_REQS + 200;   // Stalls, drains and reset
  localparam int OUT_MAX     = (1 << (`PE_OUT_W - 1)) - 1;
  localparam int OUT_MIN     = -(1 << (`PE_OUT_W - 1));

  logic        CLK;
  logic        rst_n;
  logic        req_valid;
  logic        req_ready;
  pe_req_t     req;
  logic        res_valid;
  logic        res_ready;
  pe_out_t     res;
  pe_req_t     req_q [$];    // Stimulus not yet sent
  int          exp_q [$];    // Model results, request order
  int          buf1;         // Model buffers, wrap at 32 bits like the DUT
  int          buf2;
  bit          last_prop;    // Model copy of the flip tracker
  logic [31:0] rng;
  int          errors;
  int          checks;
  int          cycles;

  pe_top dut_i (
    .CLK(CLK), .rst_n(rst_n),
    .req_valid(req_valid), .req_ready(req_ready), .req(req),
    .res_valid(res_valid), .res_ready(res_ready), .res(res)
  );

  always #20 CLK = ~CLK;  // 40 ns period

  always @(posedge CLK) begin
    cycles = cycles + 1;
    if (cycles > CYCLE_LIMIT) begin
      $display("Timeout: no result after %0d cycles, the pipeline seems stuck", cycles);
      $display("Test failed");
      $finish;
    end
  end

  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);  // xorshift32
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  // Divide by 2^s, ties to even, clamp to the 19-bit range
  function automatic int round_sat(longint v, int s);
    longint q;
    longint rem;
    longint half;
    q = v >>> s;                             // Floor
    if (s != 0) begin
      rem  = v - (q <<< s);
      half = longint'(1) <<< (s - 1);
      if (rem > half || (rem == half && q[0])) begin
        q = q + 1;
      end
    end
    if (q > OUT_MAX) begin
      q = OUT_MAX;
    end else if (q < OUT_MIN) begin
      q = OUT_MIN;
    end
    return int'(q);
  endfunction

  task automatic push_req(input int a, input int b, input int d, input bit prop, input int sh);
    pe_req_t r;
    int      drained;
    r.a         = a[`PE_OPND_W-1:0];
    r.b         = b[`PE_OPND_W-1:0];
    r.d         = d[`PE_OUT_W-1:0];
    r.propagate = prop;
    r.shift     = sh[`PE_SHIFT_W-1:0];
    drained     = prop ? buf1 : buf2;        // Value before this update
    exp_q.push_back(round_sat(longint'(drained), (prop != last_prop) ? sh : 0));
    if (prop) begin
      buf1 = d;                              // Drain then preload
      buf2 = buf2 + a * b;
    end else begin
      buf2 = d;
      buf1 = buf1 + a * b;
    end
    last_prop = prop;
    req_q.push_back(r);
  endtask

  task automatic run_stream(input string name, input bit stall);
    int          n;
    int          sent;
    int          rcvd;
    int          got;
    logic [31:0] r;
    n    = req_q.size();
    sent = 0;
    rcvd = 0;
    while (rcvd < n) begin
      @(negedge CLK);
      req_valid = sent < n;
      if (sent < n) begin
        req = req_q[sent];                   // Held until taken
      end
      r         = next_rand();
      res_ready = stall ? r[0] : 1'b1;
      #1;                                    // Ready chain settles
      if (req_valid && req_ready) begin
        sent++;
      end
      if (res_valid && res_ready) begin
        got = res;                           // Sign-extends
        checks++;
        assert (got == exp_q[rcvd]) else begin
          errors++;
          $display("Error: %s result %0d expected %0d actual %0d",
                   name, rcvd, exp_q[rcvd], got);
        end
        rcvd++;
      end
    end
    @(negedge CLK);
    req_valid = 1'b0;
    res_ready = 1'b1;
    repeat (4) begin
      @(negedge CLK);
      #1;
      checks++;
      assert (!res_valid) else begin
        errors++;
        $display("%s: DUT returned more results than the %0d requests sent", name, n);
      end
    end
    req_q.delete();
    exp_q.delete();
  endtask

  task automatic preload_drain();
    push_req(3, -5, 12345, 1'b0, 9);         // No flip after reset, shift ignored
    push_req(3, -5, -777, 1'b0, 9);          // Gets 12345 back
    run_stream("preload_drain", 1'b0);
  endtask

  task automatic mac_accumulate();
    logic [31:0] r;
    push_req(0, 0, -1500, 1'b1, 0);          // Buffer one holds d
    push_req(-128, -128, 0, 1'b0, 0);        // Corner operands
    push_req(-128, 127, 0, 1'b0, 0);
    repeat (12) begin
      r = next_rand();
      push_req(int'($signed(r[7:0])), int'($signed(r[15:8])), 0, 1'b0, 0);
    end
    push_req(0, 0, 0, 1'b1, 0);              // d plus all products
    run_stream("mac_accumulate", 1'b0);
  endtask

  task automatic round_half_even();
    int shifts [4] = '{1, 2, 3, 6};
    int bases  [4] = '{6, 7, -5, -6};        // Even and odd quotients
    int half;
    foreach (shifts[i]) begin
      half = 1 << (shifts[i] - 1);
      foreach (bases[j]) begin
        for (int off = -1; off <= 1; off++) begin  // Below, at, above half
          push_req(0, 0, (bases[j] << shifts[i]) + half + off, !last_prop, shifts[i]);
        end
      end
    end
    push_req(0, 0, 0, !last_prop, 3);        // Flush last two preloads
    push_req(0, 0, 0, !last_prop, 3);
    push_req(0, 0, 37, last_prop, 3);
    push_req(0, 0, 0, last_prop, 3);         // Repeat, so 37 unshifted
    run_stream("round_half_even", 1'b0);
  endtask

  task automatic saturation();
    bit p;
    p = !last_prop;
    push_req(0, 0, OUT_MAX, p, 0);           // Top of range
    repeat (4) begin
      push_req(127, 127, 0, !p, 0);          // Pushes past 2^18-1
    end
    push_req(0, 0, OUT_MIN, p, 0);           // Clamped high
    repeat (4) begin
      push_req(-128, 127, 0, !p, 0);
    end
    push_req(0, 0, 0, p, 0);                 // Clamped low
    run_stream("saturation", 1'b0);
  endtask

  task automatic back_pressure();
    logic [31:0] r;
    logic [31:0] s;
    repeat (STREAM_LEN) begin
      r = next_rand();
      s = next_rand();
      push_req(int'($signed(r[7:0])), int'($signed(r[15:8])),
               int'($signed(s[`PE_OUT_W-1:0])), r[16], int'(r[21:17]));
    end
    run_stream("back_pressure", 1'b1);       // res_ready toggles
  endtask

  initial begin
    CLK       = 1'b0;
    rst_n     = 1'b0;
    req_valid = 1'b0;
    req       = '0;
    res_ready = 1'b0;
    rng       = 32'h8fbd;
    buf1      = 0;
    buf2      = 0;
    last_prop = 1'b0;
    errors    = 0;
    checks    = 0;
    cycles    = 0;
    repeat (10) @(posedge CLK);
    @(negedge CLK);
    rst_n = 1'b1;
    preload_drain();
    mac_accumulate();
    round_half_even();
    saturation();
    back_pressure();
    $display("Checks: %0d  Errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+source
source/pe_pkg.sv
source/booth_mult_stage.sv
source/csa_accum_stage.sv
source/round_sat_stage.sv
source/pe_top.sv
tb/pe_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= pe_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Test failed
PASS_MSG  ?= Test completed successfully
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build $(TOP) with Verilator, run it, search $(LOG) for the fail message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG FAIL_MSG PASS_MSG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Run ended early, see $(LOG)"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
